// File: rtl/memctl_pkg.sv
/*
 * Shared types and default sizes for the RV32I memory controller.
 * Address, word and store size types plus the two request payloads.
 */

package memctl_pkg;

    // ========================================================================
    // Basic types
    // ========================================================================

    // Byte address, wraps modulo the memory size inside the controller
    typedef logic [31:0] addr_t;

    // Data or instruction word, little-endian in memory
    typedef logic [31:0] word_t;

    // Store size code, taken straight from funct3
    typedef logic [2:0] size_t;

    localparam size_t SIZE_B = 3'b000;
    localparam size_t SIZE_H = 3'b001;
    localparam size_t SIZE_W = 3'b010;

    // ========================================================================
    // Request payloads
    // ========================================================================

    // Instruction fetch, address only
    typedef struct packed {
        addr_t addr;
    } instr_req_t;

    // Data access, 68 bits in all
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        size_t size;
        logic  we;
    } data_req_t;

    // ========================================================================
    // Defaults for the top-level parameters
    // ========================================================================

    localparam int DEFAULT_MEM_BYTES   = 16384;
    localparam int DEFAULT_INSTR_DELAY = 3;
    localparam int DEFAULT_DATA_DELAY  = 2;

    // Delay counter width, enough for delays of 1 to 7 cycles
    localparam int DELAY_W = 3;

endpackage

// File: rtl/req_slot.sv
/*
 * One-entry request holding stage with valid/ready on both sides.
 * Lets a requester hand over while another access is in progress.
 */

`timescale 1ns/1ps

module req_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_payload,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_payload
);

    logic     full_q;
    payload_t payload_q;

    // Accept when empty, or when the entry leaves on this same edge
    assign in_ready    = !full_q || out_ready;
    assign out_valid   = full_q;
    assign out_payload = payload_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            full_q <= 1'b1;
        end else if (out_ready) begin
            full_q <= 1'b0;
        end
    end

    // Payload only moves on an accepted request
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            payload_q <= in_payload;
        end
    end

endmodule

// File: rtl/access_sequencer.sv
/*
 * Access sequencer for the shared memory.
 * Picks the next request, data before fetch, holds it and counts out
 * the per-kind access delay before issuing one op to the memory stage.
 */

`timescale 1ns/1ps

module access_sequencer #(
    parameter int INSTR_DELAY = memctl_pkg::DEFAULT_INSTR_DELAY,
    parameter int DATA_DELAY  = memctl_pkg::DEFAULT_DATA_DELAY
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // Instruction slot
    input  logic                   instr_valid,
    output logic                   instr_ready,
    input  memctl_pkg::instr_req_t instr_payload,

    // Data slot
    input  logic                   data_valid,
    output logic                   data_ready,
    input  memctl_pkg::data_req_t  data_payload,

    // Issue to the memory stage
    output logic                   op_valid,
    output logic                   op_is_instr,
    output memctl_pkg::addr_t      op_addr,
    output memctl_pkg::word_t      op_wdata,
    output memctl_pkg::size_t      op_size,
    output logic                   op_we
);

    typedef logic [memctl_pkg::DELAY_W-1:0] count_t;

    // Counter start values, D-1 so that D=1 issues in the pop cycle's successor
    localparam count_t INSTR_LOAD = count_t'(INSTR_DELAY - 1);
    localparam count_t DATA_LOAD  = count_t'(DATA_DELAY - 1);

    typedef enum logic {
        ST_IDLE,
        ST_ACTIVE
    } state_t;

    state_t            state_q;
    count_t            count_q;
    logic              is_instr_q;
    memctl_pkg::addr_t addr_q;
    memctl_pkg::word_t wdata_q;
    memctl_pkg::size_t size_q;
    logic              we_q;

    logic last_cycle;
    logic can_accept;
    logic pop_data;
    logic pop_instr;

    // ========================================================================
    // Arbitration
    // ========================================================================

    // Final delay cycle, the op goes out now
    assign last_cycle = (state_q == ST_ACTIVE) && (count_q == '0);

    // The slot for the next access is free again once the op issues
    assign can_accept = (state_q == ST_IDLE) || last_cycle;

    // Data wins, at most one ready per cycle
    assign data_ready  = can_accept && data_valid;
    assign instr_ready = can_accept && instr_valid && !data_valid;

    assign pop_data  = data_ready;
    assign pop_instr = instr_ready;

    // ========================================================================
    // State and delay counter
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ST_IDLE;
            count_q    <= '0;
            is_instr_q <= 1'b0;
        end else if (pop_data) begin
            state_q    <= ST_ACTIVE;
            count_q    <= DATA_LOAD;
            is_instr_q <= 1'b0;
        end else if (pop_instr) begin
            state_q    <= ST_ACTIVE;
            count_q    <= INSTR_LOAD;
            is_instr_q <= 1'b1;
        end else if (last_cycle) begin
            state_q <= ST_IDLE;
        end else if (state_q == ST_ACTIVE) begin
            count_q <= count_q - 1'b1;
        end
    end

    // Latched request, held for the whole access
    always_ff @(posedge clk) begin
        if (pop_data) begin
            addr_q  <= data_payload.addr;
            wdata_q <= data_payload.wdata;
            size_q  <= data_payload.size;
            we_q    <= data_payload.we;
        end else if (pop_instr) begin
            addr_q  <= instr_payload.addr;
            wdata_q <= '0;
            size_q  <= memctl_pkg::SIZE_W;
            we_q    <= 1'b0;
        end
    end

    // ========================================================================
    // Issue
    // ========================================================================

    assign op_valid    = last_cycle;
    assign op_is_instr = is_instr_q;
    assign op_addr     = addr_q;
    assign op_wdata    = wdata_q;
    assign op_size     = size_q;
    assign op_we       = we_q;

endmodule

// File: rtl/byte_mem.sv
/*
 * Byte-array memory stage.
 * Performs byte-lane stores and little-endian word reads for each issued
 * op, and returns a one-cycle response pulse on the fetch or data port.
 */

`timescale 1ns/1ps

module byte_mem #(
    parameter int MEM_BYTES = memctl_pkg::DEFAULT_MEM_BYTES
) (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              op_valid,
    input  logic              op_is_instr,
    input  memctl_pkg::addr_t op_addr,
    input  memctl_pkg::word_t op_wdata,
    input  memctl_pkg::size_t op_size,
    input  logic              op_we,

    output logic              instr_rsp_valid,
    output memctl_pkg::word_t instr_rsp_data,
    output logic              data_rsp_valid,
    output memctl_pkg::word_t data_rsp_rdata
);

    // MEM_BYTES is a power of two, so slicing the address wraps it
    localparam int IDX_W = $clog2(MEM_BYTES);

    logic [7:0]       mem [MEM_BYTES];
    logic [IDX_W-1:0] base_idx;
    logic [IDX_W-1:0] lane_idx [4];
    logic [3:0]       lane_en;
    memctl_pkg::word_t rd_word;

    // ========================================================================
    // Address lanes and byte enables
    // ========================================================================

    assign base_idx = op_addr[IDX_W-1:0];

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            lane_idx[k] = base_idx + IDX_W'(k);
        end
    end

    // Undefined size codes fall back to byte 0 only
    always_comb begin
        case (op_size)
            memctl_pkg::SIZE_H: lane_en = 4'b0011;
            memctl_pkg::SIZE_W: lane_en = 4'b1111;
            default:            lane_en = 4'b0001;
        endcase
    end

    // Word read always starts at the exact byte address
    assign rd_word = {mem[lane_idx[3]], mem[lane_idx[2]],
                      mem[lane_idx[1]], mem[lane_idx[0]]};

    // ========================================================================
    // Array update and responses
    // ========================================================================

    always_ff @(posedge clk) begin
        if (op_valid && op_we && !op_is_instr) begin
            for (int k = 0; k < 4; k++) begin
                if (lane_en[k]) begin
                    mem[lane_idx[k]] <= op_wdata[8*k +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_rsp_valid <= 1'b0;
            data_rsp_valid  <= 1'b0;
        end else begin
            instr_rsp_valid <= op_valid && op_is_instr;
            data_rsp_valid  <= op_valid && !op_is_instr;
        end
    end

    // Read data sampled before this edge's store, stores return old content
    always_ff @(posedge clk) begin
        if (op_valid && op_is_instr) begin
            instr_rsp_data <= rd_word;
        end
        if (op_valid && !op_is_instr) begin
            data_rsp_rdata <= rd_word;
        end
    end

endmodule

// File: rtl/mem_ctl_top.sv
/*
 * Sequential memory controller for a small RV32I system.
 * Fetch and data ports share one byte memory, one access at a time,
 * with data requests taking priority over fetches.
 */

`timescale 1ns/1ps

module mem_ctl_top #(
    parameter int MEM_BYTES   = memctl_pkg::DEFAULT_MEM_BYTES,
    parameter int INSTR_DELAY = memctl_pkg::DEFAULT_INSTR_DELAY,
    parameter int DATA_DELAY  = memctl_pkg::DEFAULT_DATA_DELAY
) (
    input  logic              clk,
    input  logic              rst_n,

    // Instruction fetch port
    input  logic              instr_req_valid,
    output logic              instr_req_ready,
    input  memctl_pkg::addr_t instr_addr,
    output logic              instr_rsp_valid,
    output memctl_pkg::word_t instr_rsp_data,

    // Data load/store port
    input  logic              data_req_valid,
    output logic              data_req_ready,
    input  memctl_pkg::addr_t data_addr,
    input  memctl_pkg::word_t data_wdata,
    input  memctl_pkg::size_t data_size,
    input  logic              data_we,
    output logic              data_rsp_valid,
    output memctl_pkg::word_t data_rsp_rdata
);

    memctl_pkg::instr_req_t instr_in;
    memctl_pkg::instr_req_t instr_out;
    memctl_pkg::data_req_t  data_in;
    memctl_pkg::data_req_t  data_out;

    logic instr_slot_valid;
    logic instr_slot_ready;
    logic data_slot_valid;
    logic data_slot_ready;

    logic              op_valid;
    logic              op_is_instr;
    memctl_pkg::addr_t op_addr;
    memctl_pkg::word_t op_wdata;
    memctl_pkg::size_t op_size;
    logic              op_we;

    // Pack loose request ports into payloads
    assign instr_in.addr  = instr_addr;
    assign data_in.addr   = data_addr;
    assign data_in.wdata  = data_wdata;
    assign data_in.size   = data_size;
    assign data_in.we     = data_we;

    req_slot #(.payload_t(memctl_pkg::instr_req_t)) u_instr_slot (
        .clk(clk), .rst_n(rst_n),
        .in_valid(instr_req_valid), .in_ready(instr_req_ready), .in_payload(instr_in),
        .out_valid(instr_slot_valid), .out_ready(instr_slot_ready), .out_payload(instr_out)
    );

    req_slot #(.payload_t(memctl_pkg::data_req_t)) u_data_slot (
        .clk(clk), .rst_n(rst_n),
        .in_valid(data_req_valid), .in_ready(data_req_ready), .in_payload(data_in),
        .out_valid(data_slot_valid), .out_ready(data_slot_ready), .out_payload(data_out)
    );

    access_sequencer #(.INSTR_DELAY(INSTR_DELAY), .DATA_DELAY(DATA_DELAY)) u_seq (
        .clk(clk), .rst_n(rst_n),
        .instr_valid(instr_slot_valid), .instr_ready(instr_slot_ready),
        .instr_payload(instr_out),
        .data_valid(data_slot_valid), .data_ready(data_slot_ready), .data_payload(data_out),
        .op_valid(op_valid), .op_is_instr(op_is_instr), .op_addr(op_addr),
        .op_wdata(op_wdata), .op_size(op_size), .op_we(op_we)
    );

    byte_mem #(.MEM_BYTES(MEM_BYTES)) u_mem (
        .clk(clk), .rst_n(rst_n),
        .op_valid(op_valid), .op_is_instr(op_is_instr), .op_addr(op_addr),
        .op_wdata(op_wdata), .op_size(op_size), .op_we(op_we),
        .instr_rsp_valid(instr_rsp_valid), .instr_rsp_data(instr_rsp_data),
        .data_rsp_valid(data_rsp_valid), .data_rsp_rdata(data_rsp_rdata)
    );

endmodule

// File: tests/mem_ctl_assertions.sv
/*
 * Protocol checks for the memory controller, bound to the top level.
 * Covers response pulse shape, request payload hold and data priority.
 */

`timescale 1ns/1ps

module mem_ctl_assertions (
    input logic              clk,
    input logic              rst_n,
    input logic              instr_req_valid,
    input logic              instr_req_ready,
    input memctl_pkg::addr_t instr_addr,
    input logic              instr_rsp_valid,
    input logic              data_req_valid,
    input logic              data_req_ready,
    input memctl_pkg::addr_t data_addr,
    input memctl_pkg::word_t data_wdata,
    input memctl_pkg::size_t data_size,
    input logic              data_we,
    input logic              data_rsp_valid,
    input logic              instr_slot_valid,
    input logic              instr_slot_ready,
    input logic              data_slot_valid
);

    // Response pulses last exactly one cycle
    a_instr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        instr_rsp_valid |=> !instr_rsp_valid)
        else $error("instr_rsp_valid high for two cycles in a row");

    a_data_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        data_rsp_valid |=> !data_rsp_valid)
        else $error("data_rsp_valid high for two cycles in a row");

    // One access at a time, so never two responses together
    a_one_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        !(instr_rsp_valid && data_rsp_valid))
        else $error("instr_rsp_valid and data_rsp_valid high together");

    // Requester holds its payload until accepted
    a_instr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        instr_req_valid && !instr_req_ready |=> $stable(instr_addr))
        else $error("instr_addr changed while waiting for ready");

    a_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        data_req_valid && !data_req_ready
            |=> $stable({data_addr, data_wdata, data_size, data_we}))
        else $error("data request payload changed while waiting for ready");

    // Data slot always wins over the fetch slot
    a_data_first: assert property (@(posedge clk) disable iff (!rst_n)
        instr_slot_valid && instr_slot_ready |-> !data_slot_valid)
        else $error("fetch popped while the data slot was valid");

endmodule

bind mem_ctl_top mem_ctl_assertions u_assertions (
    .clk(clk), .rst_n(rst_n),
    .instr_req_valid(instr_req_valid), .instr_req_ready(instr_req_ready),
    .instr_addr(instr_addr), .instr_rsp_valid(instr_rsp_valid),
    .data_req_valid(data_req_valid), .data_req_ready(data_req_ready),
    .data_addr(data_addr), .data_wdata(data_wdata), .data_size(data_size),
    .data_we(data_we), .data_rsp_valid(data_rsp_valid),
    .instr_slot_valid(instr_slot_valid), .instr_slot_ready(instr_slot_ready),
    .data_slot_valid(data_slot_valid)
);

// File: tests/mem_ctl_tb.sv
/*
 * Testbench for the memory controller.
 * Directed and random fetch/load/store traffic, checked against a
 * byte-array reference model with one expected queue per port.
 */

`timescale 1ns/1ps

module mem_ctl_tb;

    localparam int MEM_BYTES   = memctl_pkg::DEFAULT_MEM_BYTES;
    localparam int INSTR_DELAY = memctl_pkg::DEFAULT_INSTR_DELAY;
    localparam int DATA_DELAY  = memctl_pkg::DEFAULT_DATA_DELAY;
    localparam int WAIT_LIMIT  = 2000;

    // One request as offered and as expected back
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [2:0]  size;
        logic        we;
        logic        chk_lat;
        logic [1:0]  gap;
        logic [31:0] hs_cycle;
    } req_t;

    logic              clk;
    logic              rst_n;
    logic              instr_req_valid;
    logic              instr_req_ready;
    memctl_pkg::addr_t instr_addr;
    logic              instr_rsp_valid;
    memctl_pkg::word_t instr_rsp_data;
    logic              data_req_valid;
    logic              data_req_ready;
    memctl_pkg::addr_t data_addr;
    memctl_pkg::word_t data_wdata;
    memctl_pkg::size_t data_size;
    logic              data_we;
    logic              data_rsp_valid;
    memctl_pkg::word_t data_rsp_rdata;

    logic [7:0] ref_mem [MEM_BYTES];
    req_t       data_exp[$];
    req_t       instr_exp[$];
    req_t       data_todo[$];
    req_t       instr_todo[$];
    int         cycle = 0;
    int         errors = 0;
    int         checks = 0;
    int         data_sent = 0;
    int         data_rcvd = 0;
    int         instr_sent = 0;
    int         instr_rcvd = 0;
    int         last_data_rsp = 0;
    int         last_instr_rsp = 0;

    mem_ctl_top #(
        .MEM_BYTES(MEM_BYTES), .INSTR_DELAY(INSTR_DELAY), .DATA_DELAY(DATA_DELAY)
    ) dut0 (
        .clk(clk), .rst_n(rst_n),
        .instr_req_valid(instr_req_valid), .instr_req_ready(instr_req_ready),
        .instr_addr(instr_addr), .instr_rsp_valid(instr_rsp_valid),
        .instr_rsp_data(instr_rsp_data),
        .data_req_valid(data_req_valid), .data_req_ready(data_req_ready),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_size(data_size),
        .data_we(data_we), .data_rsp_valid(data_rsp_valid), .data_rsp_rdata(data_rsp_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // ========================================================================
    // Reference model
    // ========================================================================

    // Little-endian word starting at the exact byte address
    function automatic logic [31:0] exp_word(input logic [31:0] addr);
        logic [31:0] w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = ref_mem[(addr + k) % MEM_BYTES];
        end
        return w;
    endfunction

    // SH writes two bytes and SW four while any other code writes byte 0 only
    function automatic void ref_store(input req_t r);
        int nbytes;
        case (r.size)
            memctl_pkg::SIZE_H: nbytes = 2;
            memctl_pkg::SIZE_W: nbytes = 4;
            default:            nbytes = 1;
        endcase
        for (int k = 0; k < nbytes; k++) begin
            ref_mem[(r.addr + k) % MEM_BYTES] = r.wdata[8*k +: 8];
        end
    endfunction

    function automatic req_t mk_req(input logic [31:0] addr, input logic [31:0] wdata,
                                    input logic [2:0] size, input logic we,
                                    input logic chk_lat);
        req_t r;
        r = '0;
        r.addr    = addr;
        r.wdata   = wdata;
        r.size    = size;
        r.we      = we;
        r.chk_lat = chk_lat;
        return r;
    endfunction

    // ========================================================================
    // Response checking in execution order
    // ========================================================================

    always @(negedge clk) begin
        req_t r;
        int   lat;
        if (rst_n && data_rsp_valid) begin
            data_rcvd++;
            if (data_exp.size() == 0) begin
                $display("FAIL %0t data response arrived with no request outstanding", $time);
                errors++;
            end else begin
                r = data_exp.pop_front();
                lat = cycle - int'(r.hs_cycle);
                last_data_rsp = cycle;
                if (r.we) begin
                    ref_store(r);
                end else begin
                    checks++;
                    if (data_rsp_rdata !== exp_word(r.addr)) begin
                        $display("FAIL %0t data_rsp_rdata got %h exp %h", $time,
                                 data_rsp_rdata, exp_word(r.addr));
                        errors++;
                    end
                end
                if (r.chk_lat && lat != 1 + DATA_DELAY) begin
                    $display("FAIL %0t data_rsp_valid latency got %0d exp %0d", $time,
                             lat, 1 + DATA_DELAY);
                    errors++;
                end
            end
        end
        if (rst_n && instr_rsp_valid) begin
            instr_rcvd++;
            if (instr_exp.size() == 0) begin
                $display("FAIL %0t fetch response arrived with no request outstanding", $time);
                errors++;
            end else begin
                r = instr_exp.pop_front();
                lat = cycle - int'(r.hs_cycle);
                last_instr_rsp = cycle;
                checks++;
                if (instr_rsp_data !== exp_word(r.addr)) begin
                    $display("FAIL %0t instr_rsp_data got %h exp %h", $time,
                             instr_rsp_data, exp_word(r.addr));
                    errors++;
                end
                if (r.chk_lat && lat != 1 + INSTR_DELAY) begin
                    $display("FAIL %0t instr_rsp_valid latency got %0d exp %0d", $time,
                             lat, 1 + INSTR_DELAY);
                    errors++;
                end
            end
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    // Called 1 ns after a rising edge and returns 1 ns after the handshake edge
    task automatic put_req(input logic to_data, input req_t r);
        int waited;
        waited = 0;
        repeat (r.gap) begin
            @(posedge clk);
            #1;
        end
        if (to_data) begin
            data_req_valid = 1'b1;
            data_addr      = r.addr;
            data_wdata     = r.wdata;
            data_size      = r.size;
            data_we        = r.we;
        end else begin
            instr_req_valid = 1'b1;
            instr_addr      = r.addr;
        end
        @(negedge clk);
        while (!(to_data ? data_req_ready : instr_req_ready) && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        r.hs_cycle = cycle + 1;
        if (!(to_data ? data_req_ready : instr_req_ready)) begin
            $display("Timeout: request to %h was never accepted", r.addr);
            errors++;
        end else if (to_data) begin
            data_exp.push_back(r);
            data_sent++;
        end else begin
            instr_exp.push_back(r);
            instr_sent++;
        end
        @(posedge clk);
        #1;
        if (to_data) data_req_valid = 1'b0;
        else instr_req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clk);
        while ((data_exp.size() != 0 || instr_exp.size() != 0) && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (data_exp.size() != 0 || instr_exp.size() != 0) begin
            $display("Timeout: %0d data and %0d fetch responses never arrived",
                     data_exp.size(), instr_exp.size());
            errors++;
            data_exp.delete();
            instr_exp.delete();
        end
        #1;
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) $display("test %s: ok", name);
        else $display("test %s: %0d error(s)", name, errors - err_before);
    endtask

    initial begin
        int   test_err;
        int   kind;
        int   sent_before;
        req_t r;
        void'($urandom(60));
        rst_n = 1'b0;
        instr_req_valid = 1'b0;
        instr_addr = '0;
        data_req_valid = 1'b0;
        data_addr = '0;
        data_wdata = '0;
        data_size = '0;
        data_we = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Outputs idle and both slots empty right after reset
        test_err = errors;
        @(negedge clk);
        checks += 2;
        if ({instr_rsp_valid, data_rsp_valid} !== 2'b00) begin
            $display("FAIL %0t {instr_rsp_valid,data_rsp_valid} got %b exp 00", $time,
                     {instr_rsp_valid, data_rsp_valid});
            errors++;
        end
        if ({instr_req_ready, data_req_ready} !== 2'b11) begin
            $display("FAIL %0t {instr_req_ready,data_req_ready} got %b exp 11", $time,
                     {instr_req_ready, data_req_ready});
            errors++;
        end
        @(posedge clk);
        #1;
        report_test("reset", test_err);

        test_err = errors;
        put_req(1'b1, mk_req(32'h40, $urandom(), memctl_pkg::SIZE_W, 1'b1, 1'b1));
        wait_drain();
        put_req(1'b1, mk_req(32'h40, 32'h0, memctl_pkg::SIZE_W, 1'b0, 1'b1));
        wait_drain();
        report_test("word_store_load", test_err);

        test_err = errors;
        put_req(1'b1, mk_req(32'h80, 32'h11223344, memctl_pkg::SIZE_W, 1'b1, 1'b0));
        put_req(1'b1, mk_req(32'h81, 32'h000000AA, memctl_pkg::SIZE_B, 1'b1, 1'b0));
        put_req(1'b1, mk_req(32'h82, 32'h0000BBCC, memctl_pkg::SIZE_H, 1'b1, 1'b0));
        put_req(1'b1, mk_req(32'h80, 32'h0, memctl_pkg::SIZE_W, 1'b0, 1'b0));
        put_req(1'b1, mk_req(32'h80, 32'hDEADBEEF, 3'b011, 1'b1, 1'b0));
        put_req(1'b1, mk_req(32'h80, 32'h0, memctl_pkg::SIZE_W, 1'b0, 1'b0));
        wait_drain();
        report_test("byte_lanes", test_err);

        test_err = errors;
        put_req(1'b0, mk_req(32'h40, 32'h0, memctl_pkg::SIZE_W, 1'b0, 1'b1));
        wait_drain();
        put_req(1'b0, mk_req(32'h80, 32'h0, memctl_pkg::SIZE_W, 1'b0, 1'b1));
        wait_drain();
        report_test("fetch", test_err);

        // Both requests land on the same edge and data must be served first
        test_err = errors;
        fork
            put_req(1'b1, mk_req(32'h40, 32'h0, memctl_pkg::SIZE_W, 1'b0, 1'b0));
            put_req(1'b0, mk_req(32'h80, 32'h0, memctl_pkg::SIZE_W, 1'b0, 1'b0));
        join
        wait_drain();
        checks++;
        if (last_data_rsp >= last_instr_rsp) begin
            $display("Data response at edge %0d did not come before fetch response at %0d",
                     last_data_rsp, last_instr_rsp);
            errors++;
        end
        report_test("priority", test_err);

        // Fill the 256-byte window plus the 3 bytes a word read runs past it
        test_err = errors;
        for (int a = 32'h100; a < 32'h204; a += 4) begin
            put_req(1'b1, mk_req(a, $urandom(), memctl_pkg::SIZE_W, 1'b1, 1'b0));
        end
        wait_drain();
        for (int n = 0; n < 200; n++) begin
            kind = $urandom_range(4, 0);
            r = mk_req(32'h100 + $urandom_range(255, 0), $urandom(),
                       memctl_pkg::size_t'(kind), kind < 3, 1'b0);
            r.gap = ($urandom_range(3, 0) == 0) ? 2'($urandom_range(2, 1)) : 2'd0;
            if (kind == 4) instr_todo.push_back(r);
            else data_todo.push_back(r);
        end
        sent_before = data_sent + instr_sent;
        fork
            while (data_todo.size() != 0) put_req(1'b1, data_todo.pop_front());
            while (instr_todo.size() != 0) put_req(1'b0, instr_todo.pop_front());
        join
        wait_drain();
        checks++;
        if (data_sent + instr_sent - sent_before != 200 || data_sent != data_rcvd ||
            instr_sent != instr_rcvd) begin
            $display("Request/response count mismatch: data %0d/%0d, fetch %0d/%0d",
                     data_sent, data_rcvd, instr_sent, instr_rcvd);
            errors++;
        end
        report_test("random_traffic", test_err);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: vlog.f
rtl/memctl_pkg.sv
rtl/req_slot.sv
rtl/access_sequencer.sv
rtl/byte_mem.sv
rtl/mem_ctl_top.sv
tests/mem_ctl_assertions.sv
tests/mem_ctl_tb.sv

// File: Makefile
# Verilator build, run and lint for the memory controller testbench

VERILATOR  := verilator
TOP        := mem_ctl_tb
FILELIST   := vlog.f
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the simulator exit code
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
